/* list.f */
rtl/rv_isa_pkg.sv
rtl/id_ctrl_pkg.sv
rtl/inst_decoder.sv
rtl/operand_fetch.sv
rtl/branch_resolve.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
test/tb_clk_gen.sv
test/tb_id_stage.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_id_stage
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

.PHONY: sim clean

/* test/tb_id_stage.sv */
// Directed testbench for the RV32I decode stage
// drives instructions on the falling edge, checks the combinational outputs
// in the same cycle and the decode-to-execute register after the next edge

`timescale 1ns/1ps

module tb_id_stage
   import rv_isa_pkg::*;
   import id_ctrl_pkg::*;
();

   localparam word_t RST_LINK   = 32'h0000_0100;
   localparam int    MAX_CYCLES = 400;            // several times the directed run

   logic      clk;
   logic      rst_n;
   word_t     pc;
   word_t     inst;
   logic      pdt_res;
   fwd_src_t  ex_fwd;
   fwd_src_t  mem_fwd;
   logic      ex_is_load;
   word_t     reg1_data;
   word_t     reg2_data;
   logic      reg1_read;
   logic      reg2_read;
   reg_addr_t reg1_addr;
   reg_addr_t reg2_addr;
   logic      branch_flag;
   word_t     branch_target;
   logic      jump_stall;
   logic      is_branch;
   logic      branch_taken;
   logic      pdt_true;
   logic      load_stall;
   id_ex_t    id_ex;

   int seed   = 46;
   int checks = 0;
   int errors = 0;
   int cycles = 0;

   tb_clk_gen #(.PERIOD_NS (10), .RST_CYCLES (4)) u_clk (.clk_o (clk), .rst_n_o (rst_n));

   id_stage #(
      .RESET_PC_LINK (RST_LINK)
   ) dut (
      .clk             (clk),           .rst_n_i         (rst_n),
      .pc_i            (pc),            .inst_i          (inst),
      .pdt_res_i       (pdt_res),
      .ex_fwd_i        (ex_fwd),        .mem_fwd_i       (mem_fwd),
      .ex_is_load_i    (ex_is_load),
      .reg1_data_i     (reg1_data),     .reg2_data_i     (reg2_data),
      .reg1_read_o     (reg1_read),     .reg2_read_o     (reg2_read),
      .reg1_addr_o     (reg1_addr),     .reg2_addr_o     (reg2_addr),
      .branch_flag_o   (branch_flag),   .branch_target_o (branch_target),
      .jump_stall_o    (jump_stall),    .is_branch_o     (is_branch),
      .branch_taken_o  (branch_taken),  .pdt_true_o      (pdt_true),
      .load_stall_o    (load_stall),    .id_ex_o         (id_ex)
   );

   // ------------------------------
   // instruction encoders and reference helpers

   function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, funct3_t f3,
                                   reg_addr_t rd, opcode_t opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic word_t enc_r(funct7_t f7, reg_addr_t rs2, reg_addr_t rs1, funct3_t f3,
                                   reg_addr_t rd);
      return {f7, rs2, rs1, f3, rd, OPC_OP};
   endfunction

   function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                   funct3_t f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
   endfunction

   function automatic word_t enc_b(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                   funct3_t f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
   endfunction

   function automatic word_t enc_u(logic [19:0] imm, reg_addr_t rd, opcode_t opc);
      return {imm, rd, opc};
   endfunction

   function automatic word_t enc_j(logic [20:0] off, reg_addr_t rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
   endfunction

   function automatic word_t sext(word_t v, int bits);
      return word_t'($signed(v << (32 - bits)) >>> (32 - bits));
   endfunction

   function automatic fwd_src_t mk_fwd(logic wreg, reg_addr_t wd, word_t wdata);
      fwd_src_t f;
      f.wreg  = wreg;
      f.wd    = wd;
      f.wdata = wdata;
      return f;
   endfunction

   function automatic logic cond_holds(funct3_t f3, word_t a, word_t b);
      word_t sa;
      word_t sb;
      sa = a ^ 32'h8000_0000;                    // biased so unsigned order is signed order
      sb = b ^ 32'h8000_0000;
      case (f3)
         F3_BEQ:  return a == b;
         F3_BNE:  return a != b;
         F3_BLT:  return sa < sb;
         F3_BGE:  return !(sa < sb);
         F3_BLTU: return a < b;
         default: return !(a < b);
      endcase
   endfunction

   // ------------------------------
   // drive and check

   task automatic check_val(string name, word_t exp, word_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic init_inputs();
      pc         = 32'h0000_1000;
      inst       = '0;
      pdt_res    = 1'b0;
      ex_fwd     = '0;
      mem_fwd    = '0;
      ex_is_load = 1'b0;
      reg1_data  = '0;
      reg2_data  = '0;
   endtask

   task automatic present(word_t instr);
      @(negedge clk);
      inst = instr;
   endtask

   task automatic clock_edge();
      @(posedge clk);
      #1;
   endtask

   task automatic check_id_ex(alu_op_e op, alu_sel_e sel, reg_addr_t wd, logic wreg,
                              word_t r1, word_t r2);
      check_val("id_ex_o.aluop", word_t'(op), word_t'(id_ex.aluop));
      check_val("id_ex_o.alusel", word_t'(sel), word_t'(id_ex.alusel));
      check_val("id_ex_o.wd", word_t'(wd), word_t'(id_ex.wd));
      check_val("id_ex_o.wreg", word_t'(wreg), word_t'(id_ex.wreg));
      check_val("id_ex_o.reg1", r1, id_ex.reg1);
      check_val("id_ex_o.reg2", r2, id_ex.reg2);
   endtask

   task automatic alu_case(word_t instr, alu_op_e op, alu_sel_e sel, word_t r1, word_t r2);
      present(instr);
      clock_edge();
      check_id_ex(op, sel, instr[11:7], 1'b1, r1, r2);
      check_val("id_ex_o.inst", instr, id_ex.inst);
   endtask

   task automatic fwd_case(fwd_src_t ex, fwd_src_t mem, word_t instr, word_t exp_r1);
      present(instr);
      ex_fwd  = ex;
      mem_fwd = mem;
      clock_edge();
      check_val("id_ex_o.reg1", exp_r1, id_ex.reg1);
   endtask

   // ------------------------------
   // directed tests

   task automatic test_reset_bubble();
      check_id_ex(ALU_NOP, SEL_NOP, 5'd0, 1'b0, 32'h0, 32'h0);
      check_val("id_ex_o.link_addr", RST_LINK, id_ex.link_addr);
      check_val("id_ex_o.inst", 32'h0, id_ex.inst);
   endtask

   task automatic test_alu_ops();
      word_t a;
      word_t b;
      a = $random(seed);
      b = $random(seed);
      @(negedge clk);
      reg1_data = a;
      reg2_data = b;
      pc        = 32'h0000_4000;
      alu_case(enc_i(12'hF85, 5'd1, 3'b000, 5'd5, OPC_OP_IMM), ALU_ADD, SEL_ARITH, a,
               sext(32'h0000_0F85, 12));
      alu_case(enc_i(12'hFFF, 5'd1, 3'b010, 5'd5, OPC_OP_IMM), ALU_SLT, SEL_ARITH, a,
               32'hFFFF_FFFF);
      alu_case(enc_i(12'h800, 5'd1, 3'b011, 5'd5, OPC_OP_IMM), ALU_SLTU, SEL_ARITH, a,
               sext(32'h0000_0800, 12));
      alu_case(enc_i(12'h0F0, 5'd1, 3'b100, 5'd6, OPC_OP_IMM), ALU_XOR, SEL_LOGIC, a,
               32'h0000_00F0);
      alu_case(enc_i(12'h123, 5'd1, 3'b110, 5'd6, OPC_OP_IMM), ALU_OR, SEL_LOGIC, a,
               32'h0000_0123);
      alu_case(enc_i(12'h7FF, 5'd1, 3'b111, 5'd6, OPC_OP_IMM), ALU_AND, SEL_LOGIC, a,
               32'h0000_07FF);
      alu_case(enc_i({7'b0, 5'd7}, 5'd1, 3'b001, 5'd7, OPC_OP_IMM), ALU_SLL, SEL_SHIFT, a,
               32'd7);
      alu_case(enc_i({7'b0, 5'd31}, 5'd1, 3'b101, 5'd7, OPC_OP_IMM), ALU_SRL, SEL_SHIFT, a,
               32'd31);
      alu_case(enc_i({F7_ALT, 5'd3}, 5'd1, 3'b101, 5'd7, OPC_OP_IMM), ALU_SRA, SEL_SHIFT, a,
               32'd3);                                     // shamt only, no alt bit
      alu_case(enc_r(7'd0, 5'd2, 5'd1, 3'b000, 5'd8), ALU_ADD, SEL_ARITH, a, b);
      alu_case(enc_r(F7_ALT, 5'd2, 5'd1, 3'b000, 5'd8), ALU_SUB, SEL_ARITH, a, b);
      alu_case(enc_r(7'd0, 5'd2, 5'd1, 3'b001, 5'd8), ALU_SLL, SEL_SHIFT, a, b);
      alu_case(enc_r(7'd0, 5'd2, 5'd1, 3'b010, 5'd8), ALU_SLT, SEL_ARITH, a, b);
      alu_case(enc_r(7'd0, 5'd2, 5'd1, 3'b011, 5'd8), ALU_SLTU, SEL_ARITH, a, b);
      alu_case(enc_r(7'd0, 5'd2, 5'd1, 3'b100, 5'd8), ALU_XOR, SEL_LOGIC, a, b);
      alu_case(enc_r(7'd0, 5'd2, 5'd1, 3'b101, 5'd8), ALU_SRL, SEL_SHIFT, a, b);
      alu_case(enc_r(F7_ALT, 5'd2, 5'd1, 3'b101, 5'd8), ALU_SRA, SEL_SHIFT, a, b);
      alu_case(enc_r(7'd0, 5'd2, 5'd1, 3'b110, 5'd8), ALU_OR, SEL_LOGIC, a, b);
      alu_case(enc_r(7'd0, 5'd2, 5'd1, 3'b111, 5'd8), ALU_AND, SEL_LOGIC, a, b);
      alu_case(enc_u(20'hABCDE, 5'd9, OPC_LUI), ALU_OR, SEL_LOGIC, 32'h0, 32'hABCD_E000);
      alu_case(enc_u(20'h00012, 5'd9, OPC_AUIPC), ALU_OR, SEL_LOGIC, 32'h0,
               32'h0000_4000 + 32'h0001_2000);
   endtask

   task automatic test_forwarding();
      word_t a;
      word_t x;
      word_t y;
      word_t instr;
      a     = $random(seed);
      x     = $random(seed);
      y     = $random(seed);
      instr = enc_r(7'd0, 5'd4, 5'd3, 3'b000, 5'd6);
      @(negedge clk);
      reg1_data = a;
      fwd_case(mk_fwd(1'b1, 5'd3, x), mk_fwd(1'b1, 5'd3, y), instr, x);   // ex is youngest
      fwd_case(mk_fwd(1'b0, 5'd3, x), mk_fwd(1'b1, 5'd3, y), instr, y);
      fwd_case(mk_fwd(1'b1, 5'd9, x), mk_fwd(1'b1, 5'd8, y), instr, a);
      fwd_case(mk_fwd(1'b1, 5'd0, x), mk_fwd(1'b1, 5'd0, y),
               enc_r(7'd0, 5'd4, 5'd0, 3'b000, 5'd6), 32'h0);
   endtask

   task automatic test_load_store();
      word_t a;
      word_t b;
      a = $random(seed);
      b = $random(seed);
      present(enc_i(12'h010, 5'd2, 3'b010, 5'd9, OPC_LOAD));
      ex_fwd    = '0;
      mem_fwd   = '0;
      reg1_data = a;
      reg2_data = b;
      #1;
      check_val("reg1_read_o", 32'd1, word_t'(reg1_read));
      check_val("reg2_read_o", 32'd0, word_t'(reg2_read));
      check_val("reg1_addr_o", 32'd2, word_t'(reg1_addr));
      clock_edge();
      check_id_ex(ALU_LW, SEL_LOAD_STORE, 5'd9, 1'b1, a, 32'h0000_0010);
      present(enc_s(12'hFF8, 5'd10, 5'd2, 3'b000));
      #1;
      check_val("reg1_read_o", 32'd1, word_t'(reg1_read));
      check_val("reg2_read_o", 32'd1, word_t'(reg2_read));
      check_val("reg2_addr_o", 32'd10, word_t'(reg2_addr));
      clock_edge();
      check_val("id_ex_o.aluop", word_t'(ALU_SB), word_t'(id_ex.aluop));
      check_val("id_ex_o.wreg", 32'd0, word_t'(id_ex.wreg));
      check_val("id_ex_o.reg2", b, id_ex.reg2);
   endtask

   task automatic test_load_use();
      word_t y;
      word_t instr;
      y     = $random(seed);
      instr = enc_i(12'h024, 5'd5, 3'b000, 5'd1, OPC_JALR);
      present(instr);
      pc         = 32'h0000_5000;
      ex_is_load = 1'b1;
      ex_fwd     = mk_fwd(1'b1, 5'd5, 32'hDEAD_0000);
      #1;
      check_val("load_stall_o", 32'd1, word_t'(load_stall));
      check_val("branch_flag_o", 32'd0, word_t'(branch_flag));
      check_val("jump_stall_o", 32'd0, word_t'(jump_stall));
      clock_edge();
      check_id_ex(ALU_NOP, SEL_NOP, 5'd0, 1'b0, 32'h0, 32'h0);
      check_val("id_ex_o.link_addr", 32'h0, id_ex.link_addr);
      check_val("id_ex_o.inst", 32'h0, id_ex.inst);
      @(negedge clk);
      ex_is_load = 1'b0;                          // load has moved on to mem
      ex_fwd     = '0;
      mem_fwd    = mk_fwd(1'b1, 5'd5, y);
      #1;
      check_val("load_stall_o", 32'd0, word_t'(load_stall));
      check_val("branch_flag_o", 32'd1, word_t'(branch_flag));
      check_val("jump_stall_o", 32'd1, word_t'(jump_stall));
      check_val("branch_target_o", y + 32'h0000_0024, branch_target);
      clock_edge();
      check_id_ex(ALU_NOP, SEL_JUMP_BRANCH, 5'd1, 1'b1, y, 32'h0000_0024);
      check_val("id_ex_o.link_addr", 32'h0000_5004, id_ex.link_addr);
      check_val("id_ex_o.inst", instr, id_ex.inst);
   endtask

   task automatic test_branches();
      funct3_t     conds [6];
      word_t       a;
      word_t       b;
      word_t       target;
      logic [12:0] off;
      logic        taken;
      logic        mispredict;
      int          c;
      int          t;
      conds = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
      for (c = 0; c < 6; c++)
      begin
         for (t = 0; t < 4; t++)
         begin
            a = $random(seed);
            if (t < 2)
               b = a;                            // equal operands first
            else if (t == 2)
               b = $random(seed);
            else
               b = a ^ 32'h8000_0000;            // signed and unsigned order disagree
            off = t[0] ? 13'h1FF0 : 13'h0124;
            present(enc_b(off, 5'd12, 5'd11, conds[c]));
            pc        = pc + 32'h0000_0040;
            pdt_res   = t[0];
            mem_fwd   = '0;
            reg1_data = a;
            reg2_data = b;
            #1;
            taken      = cond_holds(conds[c], a, b);
            mispredict = taken != pdt_res;
            target     = taken ? pc + sext({19'd0, off}, 13) : pc + 32'd4;
            check_val("is_branch_o", 32'd1, word_t'(is_branch));
            check_val("branch_taken_o", word_t'(taken), word_t'(branch_taken));
            check_val("pdt_true_o", word_t'(!mispredict), word_t'(pdt_true));
            check_val("branch_flag_o", word_t'(mispredict), word_t'(branch_flag));
            check_val("jump_stall_o", word_t'(mispredict), word_t'(jump_stall));
            if (mispredict)
               check_val("branch_target_o", target, branch_target);
         end
      end
   endtask

   task automatic test_jumps();
      word_t a;
      a = $random(seed);
      present(enc_j(21'h0_1234, 5'd1));
      pc = 32'h0000_8000;
      #1;
      check_val("branch_flag_o", 32'd1, word_t'(branch_flag));
      check_val("jump_stall_o", 32'd1, word_t'(jump_stall));
      check_val("is_branch_o", 32'd0, word_t'(is_branch));
      check_val("branch_target_o", 32'h0000_8000 + sext(32'h0000_1234, 21), branch_target);
      clock_edge();
      check_val("id_ex_o.link_addr", 32'h0000_8004, id_ex.link_addr);
      check_val("id_ex_o.wreg", 32'd1, word_t'(id_ex.wreg));
      check_val("id_ex_o.wd", 32'd1, word_t'(id_ex.wd));
      present(enc_i(12'h7FF, 5'd13, 3'b000, 5'd1, OPC_JALR));
      reg1_data = a;
      #1;
      check_val("branch_flag_o", 32'd1, word_t'(branch_flag));
      check_val("jump_stall_o", 32'd1, word_t'(jump_stall));
      check_val("branch_target_o", a + 32'h0000_07FF, branch_target);   // odd target kept
      clock_edge();
      check_val("id_ex_o.link_addr", 32'h0000_8004, id_ex.link_addr);
      check_val("id_ex_o.wreg", 32'd1, word_t'(id_ex.wreg));
   endtask

   // ------------------------------

   initial
   begin
      while (cycles < MAX_CYCLES)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

   initial
   begin
      init_inputs();
      @(posedge rst_n);
      #1;
      test_reset_bubble();
      test_alu_ops();
      test_forwarding();
      test_load_store();
      test_load_use();
      test_branches();
      test_jumps();
      $display("run finished: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

/* test/tb_clk_gen.sv */
// Clock and reset source for the decode stage testbench
// free-running clock, reset held low for a few cycles after time zero

`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD_NS  = 10,
   parameter int RST_CYCLES = 4
)
(
   output logic clk_o,
   output logic rst_n_o
);

   initial
   begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   initial
   begin
      rst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o <= 1'b1;                  // release away from the rising edge
   end

endmodule

/* rtl/id_stage.sv */
// Top of the RV32I decode stage
// decoder, operand fetch, branch resolve and the decode-to-execute register

`timescale 1ns/1ps

module id_stage
   import rv_isa_pkg::*;
   import id_ctrl_pkg::*;
#(
   parameter word_t RESET_PC_LINK = '0
)
(
   input  logic      clk,
   input  logic      rst_n_i,
   input  word_t     pc_i,
   input  word_t     inst_i,
   input  logic      pdt_res_i,
   input  fwd_src_t  ex_fwd_i,
   input  fwd_src_t  mem_fwd_i,
   input  logic      ex_is_load_i,
   input  word_t     reg1_data_i,
   input  word_t     reg2_data_i,
   output logic      reg1_read_o,        // to register file
   output logic      reg2_read_o,
   output reg_addr_t reg1_addr_o,
   output reg_addr_t reg2_addr_o,
   output logic      branch_flag_o,      // to fetch
   output word_t     branch_target_o,
   output logic      jump_stall_o,
   output logic      is_branch_o,        // to predictor
   output logic      branch_taken_o,
   output logic      pdt_true_o,
   output logic      load_stall_o,
   output id_ex_t    id_ex_o
);

   dec_ctrl_t ctrl;
   word_t     reg1;
   word_t     reg2;
   word_t     link_addr;

   inst_decoder u_dec (
      .inst_i (inst_i),
      .pc_i   (pc_i),
      .ctrl_o (ctrl)
   );

   operand_fetch u_opf (
      .clk          (clk),          .rst_n_i      (rst_n_i),
      .inst_i       (inst_i),       .ctrl_i       (ctrl),
      .ex_fwd_i     (ex_fwd_i),     .mem_fwd_i    (mem_fwd_i),
      .ex_is_load_i (ex_is_load_i),
      .reg1_data_i  (reg1_data_i),  .reg2_data_i  (reg2_data_i),
      .reg1_read_o  (reg1_read_o),  .reg2_read_o  (reg2_read_o),
      .reg1_addr_o  (reg1_addr_o),  .reg2_addr_o  (reg2_addr_o),
      .reg1_o       (reg1),         .reg2_o       (reg2),
      .load_stall_o (load_stall_o)
   );

   branch_resolve u_br (
      .clk             (clk),             .rst_n_i        (rst_n_i),
      .pc_i            (pc_i),            .inst_i         (inst_i),
      .ctrl_i          (ctrl),
      .reg1_i          (reg1),            .reg2_i         (reg2),
      .pdt_res_i       (pdt_res_i),       .load_stall_i   (load_stall_o),
      .branch_flag_o   (branch_flag_o),   .branch_target_o (branch_target_o),
      .link_addr_o     (link_addr),       .jump_stall_o   (jump_stall_o),
      .is_branch_o     (is_branch_o),     .branch_taken_o (branch_taken_o),
      .pdt_true_o      (pdt_true_o)
   );

   id_ex_reg #(
      .RESET_PC_LINK (RESET_PC_LINK)
   ) u_idex (
      .clk          (clk),          .rst_n_i      (rst_n_i),
      .ctrl_i       (ctrl),
      .reg1_i       (reg1),         .reg2_i       (reg2),
      .link_addr_i  (link_addr),    .inst_i       (inst_i),
      .load_stall_i (load_stall_o),
      .id_ex_o      (id_ex_o)
   );

endmodule

/* rtl/id_ex_reg.sv */
// Decode-to-execute pipeline register
// a load-use stall loads a bubble in place of the instruction

`timescale 1ns/1ps

module id_ex_reg
   import rv_isa_pkg::*;
   import id_ctrl_pkg::*;
#(
   parameter word_t RESET_PC_LINK = '0
)
(
   input  logic      clk,
   input  logic      rst_n_i,
   input  dec_ctrl_t ctrl_i,
   input  word_t     reg1_i,
   input  word_t     reg2_i,
   input  word_t     link_addr_i,
   input  word_t     inst_i,
   input  logic      load_stall_i,
   output id_ex_t    id_ex_o
);

   localparam id_ex_t BUBBLE = '{aluop: ALU_NOP, alusel: SEL_NOP, reg1: '0, reg2: '0,
                                 wd: '0, wreg: 1'b0, link_addr: '0, inst: '0};

   id_ex_t id_ex_d;

   assign id_ex_d = '{aluop:     ctrl_i.aluop,
                      alusel:    ctrl_i.alusel,
                      reg1:      reg1_i,
                      reg2:      reg2_i,
                      wd:        ctrl_i.wd,
                      wreg:      ctrl_i.wreg,
                      link_addr: link_addr_i,
                      inst:      inst_i};

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         id_ex_o           <= BUBBLE;
         id_ex_o.link_addr <= RESET_PC_LINK;
      end
      else if (load_stall_i)
         id_ex_o <= BUBBLE;                    // hold execute idle
      else
         id_ex_o <= id_ex_d;
   end

   // ------------------------------
   a_stall_bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
      load_stall_i |=> !id_ex_o.wreg)
      else $error("stalled instruction reached execute with a write enable");

endmodule

/* rtl/branch_resolve.sv */
// Resolves branches and jumps in decode
// checks the predictor guess and drives the fetch redirect and link address

`timescale 1ns/1ps

module branch_resolve
   import rv_isa_pkg::*;
   import id_ctrl_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   input  word_t     pc_i,
   input  word_t     inst_i,
   input  dec_ctrl_t ctrl_i,
   input  word_t     reg1_i,
   input  word_t     reg2_i,
   input  logic      pdt_res_i,
   input  logic      load_stall_i,
   output logic      branch_flag_o,
   output word_t     branch_target_o,
   output word_t     link_addr_o,
   output logic      jump_stall_o,
   output logic      is_branch_o,
   output logic      branch_taken_o,
   output logic      pdt_true_o
);

   logic  taken;
   logic  mispredict;
   logic  is_jump;
   logic  redirect;
   word_t seq_pc;

   assign seq_pc  = pc_i + INST_BYTES;
   assign is_jump = ctrl_i.is_jal | ctrl_i.is_jalr;

   always_comb
   begin
      case (inst_i[14:12])
         F3_BEQ:  taken = (reg1_i == reg2_i);
         F3_BNE:  taken = (reg1_i != reg2_i);
         F3_BLT:  taken = ($signed(reg1_i) < $signed(reg2_i));
         F3_BGE:  taken = ($signed(reg1_i) >= $signed(reg2_i));
         F3_BLTU: taken = (reg1_i < reg2_i);
         F3_BGEU: taken = (reg1_i >= reg2_i);
         default: taken = 1'b0;
      endcase
   end

   assign mispredict = ctrl_i.is_branch && (taken != pdt_res_i);
   assign redirect   = (is_jump | mispredict) & ~load_stall_i;   // operands stale during stall

   always_comb
   begin
      if (ctrl_i.is_jalr)
         branch_target_o = reg1_i + ctrl_i.imm;      // bit 0 kept
      else if (ctrl_i.is_jal || (mispredict && taken))
         branch_target_o = pc_i + ctrl_i.imm;
      else if (mispredict)
         branch_target_o = seq_pc;                   // predicted taken, fall through
      else
         branch_target_o = '0;
   end

   assign branch_flag_o  = redirect;
   assign jump_stall_o   = redirect;
   assign link_addr_o    = is_jump ? seq_pc : '0;
   assign is_branch_o    = ctrl_i.is_branch & ~load_stall_i;
   assign branch_taken_o = ctrl_i.is_branch & taken;
   assign pdt_true_o     = ctrl_i.is_branch & (taken == pdt_res_i);

   // ------------------------------
   a_redirect_class: assert property (@(posedge clk) disable iff (!rst_n_i)
      branch_flag_o |-> (ctrl_i.is_branch || is_jump))
      else $error("redirect raised for a non-control instruction");

endmodule

/* rtl/operand_fetch.sv */
// Register-file read requests and operand selection for decode
// forwards from ex and mem and flags a load-use hazard

`timescale 1ns/1ps

module operand_fetch
   import rv_isa_pkg::*;
   import id_ctrl_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   input  word_t     inst_i,
   input  dec_ctrl_t ctrl_i,
   input  fwd_src_t  ex_fwd_i,
   input  fwd_src_t  mem_fwd_i,
   input  logic      ex_is_load_i,
   input  word_t     reg1_data_i,
   input  word_t     reg2_data_i,
   output logic      reg1_read_o,
   output logic      reg2_read_o,
   output reg_addr_t reg1_addr_o,
   output reg_addr_t reg2_addr_o,
   output word_t     reg1_o,
   output word_t     reg2_o,
   output logic      load_stall_o
);

   function automatic word_t pick_operand(logic rd_en, reg_addr_t addr, word_t rf_data,
                                          fwd_src_t ex_fwd, fwd_src_t mem_fwd, word_t imm);
      word_t val;
      if (!rd_en)
         val = imm;
      else if (addr == '0)
         val = '0;                              // x0 hardwired
      else if (ex_fwd.wreg && ex_fwd.wd == addr)
         val = ex_fwd.wdata;                    // youngest result wins
      else if (mem_fwd.wreg && mem_fwd.wd == addr)
         val = mem_fwd.wdata;
      else
         val = rf_data;
      return val;
   endfunction

   function automatic logic load_use(logic rd_en, reg_addr_t addr, reg_addr_t ex_wd,
                                     logic ex_load);
      return ex_load && rd_en && addr != '0 && ex_wd == addr;
   endfunction

   assign reg1_read_o = ctrl_i.rs1_read;
   assign reg2_read_o = ctrl_i.rs2_read;
   assign reg1_addr_o = inst_i[19:15];
   assign reg2_addr_o = inst_i[24:20];

   assign reg1_o = pick_operand(reg1_read_o, reg1_addr_o, reg1_data_i,
                                ex_fwd_i, mem_fwd_i, '0);          // imm goes to operand 2 only
   assign reg2_o = pick_operand(reg2_read_o, reg2_addr_o, reg2_data_i,
                                ex_fwd_i, mem_fwd_i, ctrl_i.imm);

   // load data not ready until after mem
   assign load_stall_o = load_use(reg1_read_o, reg1_addr_o, ex_fwd_i.wd, ex_is_load_i) |
                         load_use(reg2_read_o, reg2_addr_o, ex_fwd_i.wd, ex_is_load_i);

   // ------------------------------
   // checks

   a_no_stall_on_x0: assert property (@(posedge clk) disable iff (!rst_n_i)
      load_stall_o |-> ex_fwd_i.wd != '0)
      else $error("load stall raised against x0");

   a_x0_is_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
      ((reg1_read_o && reg1_addr_o == '0) |-> reg1_o == '0) and
      ((reg2_read_o && reg2_addr_o == '0) |-> reg2_o == '0))
      else $error("x0 operand read back nonzero");

endmodule

/* rtl/inst_decoder.sv */
// RV32I instruction decoder
// maps opcode and funct fields to control fields and builds the immediate

`timescale 1ns/1ps

module inst_decoder
   import rv_isa_pkg::*;
   import id_ctrl_pkg::*;
(
   input  word_t     inst_i,
   input  word_t     pc_i,
   output dec_ctrl_t ctrl_o
);

   opcode_t   opcode;
   funct3_t   funct3;
   funct7_t   funct7;
   reg_addr_t rd;
   word_t     imm_i;
   word_t     imm_s;
   word_t     imm_b;
   word_t     imm_u;
   word_t     imm_j;
   word_t     shamt;

   function automatic dec_ctrl_t ctl(alu_op_e op, alu_sel_e sel, logic wr, logic rd1,
                                     logic rd2, word_t imm);
      dec_ctrl_t c;
      c          = '0;
      c.aluop    = op;
      c.alusel   = sel;
      c.wreg     = wr;
      c.rs1_read = rd1;
      c.rs2_read = rd2;
      c.imm      = imm;
      return c;
   endfunction

   assign opcode = inst_i[6:0];
   assign funct3 = inst_i[14:12];
   assign funct7 = inst_i[31:25];
   assign rd     = inst_i[11:7];

   // ------------------------------
   // immediates
   assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
   assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
   assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
   assign imm_u = {inst_i[31:12], 12'h000};
   assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
   assign shamt = {27'd0, inst_i[24:20]};

   // ------------------------------
   // control decode
   always_comb
   begin
      ctrl_o = ctl(ALU_NOP, SEL_NOP, 1'b0, 1'b0, 1'b0, '0);   // unknown stays a nop
      case (opcode)
         OPC_LOAD:
         begin
            case (funct3)
               3'b000:  ctrl_o = ctl(ALU_LB, SEL_LOAD_STORE, 1'b1, 1'b1, 1'b0, imm_i);
               3'b001:  ctrl_o = ctl(ALU_LH, SEL_LOAD_STORE, 1'b1, 1'b1, 1'b0, imm_i);
               3'b010:  ctrl_o = ctl(ALU_LW, SEL_LOAD_STORE, 1'b1, 1'b1, 1'b0, imm_i);
               3'b100:  ctrl_o = ctl(ALU_LBU, SEL_LOAD_STORE, 1'b1, 1'b1, 1'b0, imm_i);
               3'b101:  ctrl_o = ctl(ALU_LHU, SEL_LOAD_STORE, 1'b1, 1'b1, 1'b0, imm_i);
               default: ;
            endcase
         end
         OPC_STORE:
         begin
            case (funct3)
               3'b000:  ctrl_o = ctl(ALU_SB, SEL_LOAD_STORE, 1'b0, 1'b1, 1'b1, imm_s);
               3'b001:  ctrl_o = ctl(ALU_SH, SEL_LOAD_STORE, 1'b0, 1'b1, 1'b1, imm_s);
               3'b010:  ctrl_o = ctl(ALU_SW, SEL_LOAD_STORE, 1'b0, 1'b1, 1'b1, imm_s);
               default: ;
            endcase
         end
         OPC_OP_IMM:
         begin
            case (funct3)
               3'b000:  ctrl_o = ctl(ALU_ADD, SEL_ARITH, 1'b1, 1'b1, 1'b0, imm_i);
               3'b010:  ctrl_o = ctl(ALU_SLT, SEL_ARITH, 1'b1, 1'b1, 1'b0, imm_i);
               3'b011:  ctrl_o = ctl(ALU_SLTU, SEL_ARITH, 1'b1, 1'b1, 1'b0, imm_i);
               3'b100:  ctrl_o = ctl(ALU_XOR, SEL_LOGIC, 1'b1, 1'b1, 1'b0, imm_i);
               3'b110:  ctrl_o = ctl(ALU_OR, SEL_LOGIC, 1'b1, 1'b1, 1'b0, imm_i);
               3'b111:  ctrl_o = ctl(ALU_AND, SEL_LOGIC, 1'b1, 1'b1, 1'b0, imm_i);
               3'b001:
               begin
                  if (funct7 == '0)
                     ctrl_o = ctl(ALU_SLL, SEL_SHIFT, 1'b1, 1'b1, 1'b0, shamt);
               end
               default:
               begin
                  if (funct7 == '0)
                     ctrl_o = ctl(ALU_SRL, SEL_SHIFT, 1'b1, 1'b1, 1'b0, shamt);
                  else if (funct7 == F7_ALT)
                     ctrl_o = ctl(ALU_SRA, SEL_SHIFT, 1'b1, 1'b1, 1'b0, shamt);
               end
            endcase
         end
         OPC_OP:
         begin
            if (funct7 == '0)
            begin
               case (funct3)
                  3'b000:  ctrl_o = ctl(ALU_ADD, SEL_ARITH, 1'b1, 1'b1, 1'b1, '0);
                  3'b001:  ctrl_o = ctl(ALU_SLL, SEL_SHIFT, 1'b1, 1'b1, 1'b1, '0);
                  3'b010:  ctrl_o = ctl(ALU_SLT, SEL_ARITH, 1'b1, 1'b1, 1'b1, '0);
                  3'b011:  ctrl_o = ctl(ALU_SLTU, SEL_ARITH, 1'b1, 1'b1, 1'b1, '0);
                  3'b100:  ctrl_o = ctl(ALU_XOR, SEL_LOGIC, 1'b1, 1'b1, 1'b1, '0);
                  3'b101:  ctrl_o = ctl(ALU_SRL, SEL_SHIFT, 1'b1, 1'b1, 1'b1, '0);
                  3'b110:  ctrl_o = ctl(ALU_OR, SEL_LOGIC, 1'b1, 1'b1, 1'b1, '0);
                  default: ctrl_o = ctl(ALU_AND, SEL_LOGIC, 1'b1, 1'b1, 1'b1, '0);
               endcase
            end
            else if (funct7 == F7_ALT && funct3 == 3'b000)
               ctrl_o = ctl(ALU_SUB, SEL_ARITH, 1'b1, 1'b1, 1'b1, '0);
            else if (funct7 == F7_ALT && funct3 == 3'b101)
               ctrl_o = ctl(ALU_SRA, SEL_SHIFT, 1'b1, 1'b1, 1'b1, '0);
         end
         OPC_LUI:   ctrl_o = ctl(ALU_OR, SEL_LOGIC, 1'b1, 1'b0, 1'b0, imm_u);
         OPC_AUIPC: ctrl_o = ctl(ALU_OR, SEL_LOGIC, 1'b1, 1'b0, 1'b0, pc_i + imm_u);
         OPC_JAL:
         begin
            ctrl_o        = ctl(ALU_NOP, SEL_JUMP_BRANCH, 1'b1, 1'b0, 1'b0, imm_j);
            ctrl_o.is_jal = 1'b1;
         end
         OPC_JALR:
         begin
            ctrl_o         = ctl(ALU_NOP, SEL_JUMP_BRANCH, 1'b1, 1'b1, 1'b0, imm_i);
            ctrl_o.is_jalr = 1'b1;
         end
         OPC_BRANCH:
         begin
            if (funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU})
            begin
               ctrl_o           = ctl(ALU_NOP, SEL_JUMP_BRANCH, 1'b0, 1'b1, 1'b1, imm_b);
               ctrl_o.is_branch = 1'b1;
            end
         end
         default: ;
      endcase
      ctrl_o.wd = rd;
   end

endmodule

/* rtl/id_ctrl_pkg.sv */
// Control encodings and bundles passed between the decode modules
// and on to the execute stage

package id_ctrl_pkg;

   import rv_isa_pkg::*;

   typedef enum logic [5:0] {
      ALU_NOP,
      ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
      ALU_XOR, ALU_OR, ALU_AND,
      ALU_SLL, ALU_SRL, ALU_SRA,
      ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU,
      ALU_SB, ALU_SH, ALU_SW
   } alu_op_e;

   // result select in execute
   typedef enum logic [2:0] {
      SEL_NOP,
      SEL_LOGIC,
      SEL_SHIFT,
      SEL_ARITH,
      SEL_LOAD_STORE,
      SEL_JUMP_BRANCH
   } alu_sel_e;

   typedef struct packed {
      alu_op_e   aluop;
      alu_sel_e  alusel;
      logic      wreg;
      reg_addr_t wd;
      logic      rs1_read;
      logic      rs2_read;
      logic      is_branch;
      logic      is_jal;
      logic      is_jalr;
      word_t     imm;
   } dec_ctrl_t;

   // write-back info of a later stage
   typedef struct packed {
      logic      wreg;
      reg_addr_t wd;
      word_t     wdata;
   } fwd_src_t;

   typedef struct packed {
      alu_op_e   aluop;
      alu_sel_e  alusel;
      word_t     reg1;
      word_t     reg2;
      reg_addr_t wd;
      logic      wreg;
      word_t     link_addr;
      word_t     inst;
   } id_ex_t;

endpackage

/* rtl/rv_isa_pkg.sv */
// RV32I base definitions shared by the decode stage
// word and field types plus the opcode and funct encodings

package rv_isa_pkg;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;

   typedef logic [XLEN-1:0]       word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [6:0]            opcode_t;
   typedef logic [2:0]            funct3_t;
   typedef logic [6:0]            funct7_t;

   // ------------------------------
   // major opcodes
   localparam opcode_t OPC_LOAD   = 7'b0000011;
   localparam opcode_t OPC_STORE  = 7'b0100011;
   localparam opcode_t OPC_OP_IMM = 7'b0010011;
   localparam opcode_t OPC_OP     = 7'b0110011;
   localparam opcode_t OPC_LUI    = 7'b0110111;
   localparam opcode_t OPC_AUIPC  = 7'b0010111;
   localparam opcode_t OPC_JAL    = 7'b1101111;
   localparam opcode_t OPC_JALR   = 7'b1100111;
   localparam opcode_t OPC_BRANCH = 7'b1100011;

   // ------------------------------
   // branch conditions
   localparam funct3_t F3_BEQ  = 3'b000;
   localparam funct3_t F3_BNE  = 3'b001;
   localparam funct3_t F3_BLT  = 3'b100;
   localparam funct3_t F3_BGE  = 3'b101;
   localparam funct3_t F3_BLTU = 3'b110;
   localparam funct3_t F3_BGEU = 3'b111;

   localparam funct7_t F7_ALT = 7'b0100000;     // sub and sra

   localparam word_t INST_BYTES = 32'd4;

endpackage
